// ==== design/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Word and register file sizes
`define DATA_WIDTH 32
`define GPR_NUM    32
`define GPR_ADDR_W $clog2(`GPR_NUM)

// Opcode field widths per format
`define OP3R_W    17 // instr[31:15]
`define OP2RI12_W 10 // instr[31:22]
`define OP1RI20_W 7  // instr[31:25]

// Immediate field widths
`define IMM12_W 12
`define IMM20_W 20

// 3R opcodes
`define OP_ADD_W 17'h00020
`define OP_SUB_W 17'h00022
`define OP_SLT   17'h00024
`define OP_SLTU  17'h00025
`define OP_NOR   17'h00028
`define OP_AND   17'h00029
`define OP_OR    17'h0002a
`define OP_XOR   17'h0002b
`define OP_SLL_W 17'h0002e
`define OP_SRL_W 17'h0002f
`define OP_SRA_W 17'h00030
`define OP_MUL_W 17'h00038

// 2RI12 arithmetic and logic
`define OP_SLTI   10'h008
`define OP_SLTUI  10'h009
`define OP_ADDI_W 10'h00a
`define OP_ANDI   10'h00d
`define OP_ORI    10'h00e
`define OP_XORI   10'h00f

// 2RI12 memory access
`define OP_LD_B  10'h0a0
`define OP_LD_H  10'h0a1
`define OP_LD_W  10'h0a2
`define OP_ST_B  10'h0a4
`define OP_ST_H  10'h0a5
`define OP_ST_W  10'h0a6
`define OP_LD_BU 10'h0a8
`define OP_LD_HU 10'h0a9
`define OP_PRELD 10'h0ab

// 1RI20 upper immediate
`define OP_LU12I_W   7'h0a
`define OP_PCADDU12I 7'h0e

`endif

// ==== design/la_isa_pkg.sv ====
`include "decode_params.svh"

package la_isa_pkg;

    // One entry from the instruction buffer
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] instr;
    } instr_buffer_info_t;

    // ALU operation, NOP must stay at zero
    typedef enum logic [7:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_LD_B,
        ALU_LD_H,
        ALU_LD_W,
        ALU_LD_BU,
        ALU_LD_HU,
        ALU_ST_B,
        ALU_ST_H,
        ALU_ST_W
    } aluop_t;

    // Result class, picks the execute unit
    typedef enum logic [2:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_LOAD_STORE
    } alusel_t;

endpackage

// ==== design/decode_pkg.sv ====
`include "decode_params.svh"

package decode_pkg;

    // Output of one format decoder, all zero unless hit
    typedef struct packed {
        logic                   hit;
        logic [1:0]             reg_read_valid; // bit 0 rj, bit 1 rk
        logic [`GPR_ADDR_W-1:0] rj;
        logic [`GPR_ADDR_W-1:0] rk;
        logic [`DATA_WIDTH-1:0] imm;
        logic                   use_pc;         // Operand A is the pc
        logic                   reg_write_valid;
        logic [`GPR_ADDR_W-1:0] rd;
        la_isa_pkg::aluop_t     aluop;
        la_isa_pkg::alusel_t    alusel;
    } decode_result_t;

    // What the stage hands to execute
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        decode_result_t         result;
        logic                   illegal;
    } decode_out_t;

endpackage

// ==== design/decoder_3r.sv ====
`include "decode_params.svh"

// 3R format {opcode[17], rk[5], rj[5], rd[5]}
module decoder_3r (
    input  la_isa_pkg::instr_buffer_info_t instr_i,
    output decode_pkg::decode_result_t     result_o
);
    import la_isa_pkg::*;

    logic [`DATA_WIDTH-1:0] instr;
    logic [`OP3R_W-1:0]     opcode;
    logic                   hit;
    aluop_t                 aluop;
    alusel_t                alusel;

    assign instr  = instr_i.instr;
    assign opcode = instr[31:15];

    always_comb begin
        hit    = 1'b1;
        aluop  = ALU_NOP;
        alusel = SEL_ARITH; // Most 3R ops land here
        case (opcode)
            `OP_ADD_W: aluop = ALU_ADD;
            `OP_SUB_W: aluop = ALU_SUB;
            `OP_SLT:   aluop = ALU_SLT;
            `OP_SLTU:  aluop = ALU_SLTU;
            `OP_MUL_W: aluop = ALU_MUL;
            `OP_NOR: begin
                aluop  = ALU_NOR;
                alusel = SEL_LOGIC;
            end
            `OP_AND: begin
                aluop  = ALU_AND;
                alusel = SEL_LOGIC;
            end
            `OP_OR: begin
                aluop  = ALU_OR;
                alusel = SEL_LOGIC;
            end
            `OP_XOR: begin
                aluop  = ALU_XOR;
                alusel = SEL_LOGIC;
            end
            `OP_SLL_W: begin
                aluop  = ALU_SLL;
                alusel = SEL_SHIFT;
            end
            `OP_SRL_W: begin
                aluop  = ALU_SRL;
                alusel = SEL_SHIFT;
            end
            `OP_SRA_W: begin
                aluop  = ALU_SRA;
                alusel = SEL_SHIFT;
            end
            default: begin
                hit    = 1'b0;
                alusel = SEL_NOP;
            end
        endcase
    end

    // Fields only come out on a match
    always_comb begin
        result_o = '0;
        if (hit) begin
            result_o.hit             = 1'b1;
            result_o.reg_read_valid  = 2'b11; // rj and rk
            result_o.rj              = instr[9:5];
            result_o.rk              = instr[14:10];
            result_o.reg_write_valid = 1'b1;
            result_o.rd              = instr[4:0];
            result_o.aluop           = aluop;
            result_o.alusel          = alusel;
        end
    end

endmodule

// ==== design/decoder_2ri12.sv ====
`include "decode_params.svh"

// 2RI12 format {opcode[10], imm[12], rj[5], rd[5]}
// Immediate arithmetic, logic and memory access
module decoder_2ri12 (
    input  la_isa_pkg::instr_buffer_info_t instr_i,
    output decode_pkg::decode_result_t     result_o
);
    import la_isa_pkg::*;

    logic [`DATA_WIDTH-1:0] instr;
    logic [`OP2RI12_W-1:0]  opcode;
    logic [`GPR_ADDR_W-1:0] rd;
    logic [`GPR_ADDR_W-1:0] rj;
    logic [`IMM12_W-1:0]    imm12;
    logic [`DATA_WIDTH-1:0] imm_sext;
    logic [`DATA_WIDTH-1:0] imm_zext;

    assign instr    = instr_i.instr;
    assign opcode   = instr[31:22];
    assign rd       = instr[4:0];
    assign rj       = instr[9:5];
    assign imm12    = instr[21:10];
    assign imm_sext = {{(`DATA_WIDTH-`IMM12_W){imm12[`IMM12_W-1]}}, imm12};
    assign imm_zext = {{(`DATA_WIDTH-`IMM12_W){1'b0}}, imm12};

    always_comb begin
        // Common case is read rj, write rd, signed offset
        result_o                 = '0;
        result_o.hit             = 1'b1;
        result_o.reg_read_valid  = 2'b01;
        result_o.rj              = rj;
        result_o.reg_write_valid = 1'b1;
        result_o.rd              = rd;
        result_o.imm             = imm_sext;
        case (opcode)
            `OP_SLTI: begin
                result_o.aluop  = ALU_SLT;
                result_o.alusel = SEL_ARITH;
            end
            `OP_SLTUI: begin
                result_o.aluop  = ALU_SLTU;
                result_o.alusel = SEL_ARITH;
            end
            `OP_ADDI_W: begin
                result_o.aluop  = ALU_ADD;
                result_o.alusel = SEL_ARITH;
            end
            `OP_ANDI: begin
                result_o.aluop  = ALU_AND;
                result_o.alusel = SEL_LOGIC;
                result_o.imm    = imm_zext;
            end
            `OP_ORI: begin
                result_o.aluop  = ALU_OR;
                result_o.alusel = SEL_LOGIC;
                result_o.imm    = imm_zext;
            end
            `OP_XORI: begin
                result_o.aluop  = ALU_XOR;
                result_o.alusel = SEL_LOGIC;
                result_o.imm    = imm_zext;
            end
            `OP_LD_B, `OP_LD_H, `OP_LD_W, `OP_LD_BU, `OP_LD_HU: begin
                result_o.alusel = SEL_LOAD_STORE;
                case (opcode)
                    `OP_LD_B: result_o.aluop = ALU_LD_B;
                    `OP_LD_H: result_o.aluop = ALU_LD_H;
                    `OP_LD_W: result_o.aluop = ALU_LD_W;
                    `OP_LD_BU: result_o.aluop = ALU_LD_BU;
                    default: result_o.aluop = ALU_LD_HU;
                endcase
            end
            `OP_ST_B, `OP_ST_H, `OP_ST_W: begin
                // Store data comes from rd, read on the rk port
                result_o.alusel          = SEL_LOAD_STORE;
                result_o.reg_read_valid  = 2'b11;
                result_o.rk              = rd;
                result_o.reg_write_valid = 1'b0;
                result_o.rd              = '0;
                case (opcode)
                    `OP_ST_B: result_o.aluop = ALU_ST_B;
                    `OP_ST_H: result_o.aluop = ALU_ST_H;
                    default: result_o.aluop = ALU_ST_W;
                endcase
            end
            `OP_PRELD: begin
                result_o.reg_write_valid = 1'b0; // Hint only
                result_o.rd              = '0;
                result_o.imm             = '0;
            end
            default: result_o = '0;
        endcase
    end

endmodule

// ==== design/decoder_1ri20.sv ====
`include "decode_params.svh"

// 1RI20 format {opcode[7], imm[20], rd[5]}
module decoder_1ri20 (
    input  la_isa_pkg::instr_buffer_info_t instr_i,
    output decode_pkg::decode_result_t     result_o
);
    import la_isa_pkg::*;

    logic [`DATA_WIDTH-1:0] instr;
    logic [`OP1RI20_W-1:0]  opcode;
    logic [`IMM20_W-1:0]    imm20;
    logic                   hit;

    assign instr  = instr_i.instr;
    assign opcode = instr[31:25];
    assign imm20  = instr[24:5];
    assign hit    = (opcode == `OP_LU12I_W) || (opcode == `OP_PCADDU12I);

    always_comb begin
        result_o = '0;
        if (hit) begin
            result_o.hit             = 1'b1;
            result_o.imm             = {imm20, {(`DATA_WIDTH-`IMM20_W){1'b0}}};
            result_o.use_pc          = (opcode == `OP_PCADDU12I); // pc + imm
            result_o.reg_write_valid = 1'b1;
            result_o.rd              = instr[4:0];
            result_o.aluop           = ALU_ADD; // Added to zero or pc
            result_o.alusel          = SEL_ARITH;
        end
    end

endmodule

// ==== design/decode_core.sv ====
// Runs all format decoders side by side and merges their results
module decode_core (
    input  logic                           valid_i,
    input  la_isa_pkg::instr_buffer_info_t instr_i,
    output decode_pkg::decode_out_t        out_o
);
    import decode_pkg::*;

    decode_result_t res_3r;
    decode_result_t res_2ri12;
    decode_result_t res_1ri20;
    decode_result_t merged;

    decoder_3r u_dec_3r (
        .instr_i  (instr_i),
        .result_o (res_3r)
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_i  (instr_i),
        .result_o (res_2ri12)
    );

    decoder_1ri20 u_dec_1ri20 (
        .instr_i  (instr_i),
        .result_o (res_1ri20)
    );

    // Non-hit results are all zero, so a plain OR selects the winner
    assign merged = decode_result_t'(res_3r | res_2ri12 | res_1ri20);

    always_comb begin
        out_o.pc      = instr_i.pc;
        out_o.result  = merged;
        out_o.illegal = valid_i && !merged.hit; // Nobody claimed it
    end

endmodule

// ==== design/pipe_reg.sv ====
// One-entry pipeline register with valid, stall and flush
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // Flush wins over stall
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

    // Held item must not move or vanish during a stall
    a_hold_on_stall: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        stall_i && !flush_i |=> $stable(valid_o) && (!valid_o || $stable(data_o))
    );

endmodule

// ==== design/decode_stage.sv ====
// Decode stage top, input register, decode and output register
module decode_stage (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           instr_valid_i,
    input  la_isa_pkg::instr_buffer_info_t instr_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    output logic                           decoded_valid_o,
    output decode_pkg::decode_out_t        decoded_o
);
    import la_isa_pkg::*;
    import decode_pkg::*;

    logic               in_valid;
    instr_buffer_info_t in_item;
    decode_out_t        core_out;

    pipe_reg #(
        .payload_t (instr_buffer_info_t)
    ) u_in_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .valid_i  (instr_valid_i),
        .data_i   (instr_i),
        .valid_o  (in_valid),
        .data_o   (in_item)
    );

    decode_core u_core (
        .valid_i (in_valid),
        .instr_i (in_item),
        .out_o   (core_out)
    );

    pipe_reg #(
        .payload_t (decode_out_t)
    ) u_out_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .valid_i  (in_valid),
        .data_i   (core_out),
        .valid_o  (decoded_valid_o),
        .data_o   (decoded_o)
    );

    // Opcode spaces are disjoint, at most one format may claim a word
    a_one_hit: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        in_valid |-> $onehot0({u_core.res_3r.hit, u_core.res_2ri12.hit,
                               u_core.res_1ri20.hit})
    );

endmodule

// ==== tests/tb_decode_stage.sv ====
`include "decode_params.svh"

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import la_isa_pkg::*;
    import decode_pkg::*;

    // Cycles per test are 10 + 8 + 11 + 16 + 8 + 17
    localparam int TOTAL_CYC  = 70;
    localparam int MARGIN_CYC = 40;

    logic               clk_i;
    logic               arst_n_i;
    logic               instr_valid_i;
    instr_buffer_info_t instr_i;
    logic               stall_i;
    logic               flush_i;
    logic               decoded_valid_o;
    decode_out_t        decoded_o;

    // Expected pipeline contents
    logic               m_in_v;
    instr_buffer_info_t m_in;
    logic               m_out_v;
    decode_out_t        m_out;

    logic [31:0] lfsr_state = 32'hbb8b;
    logic [31:0] pc_cnt = 32'h1c00_0000;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;

    decode_stage dut (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .decoded_valid_o (decoded_valid_o),
        .decoded_o       (decoded_o)
    );

    always #5 clk_i = ~clk_i;

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    // Opcode on top with random operand fields below
    function automatic logic [31:0] rand_word(input logic [31:0] op, input int op_w);
        logic [31:0] r;
        r = rand_bits(32 - op_w);
        return (op << (32 - op_w)) | r;
    endfunction

    function automatic instr_buffer_info_t next_item(input logic [31:0] w);
        instr_buffer_info_t it;
        it.pc    = pc_cnt;
        it.instr = w;
        pc_cnt   = pc_cnt + 4;
        return it;
    endfunction

    // Expected decode of one word
    function automatic decode_out_t ref_decode(input instr_buffer_info_t item);
        decode_out_t o;
        logic [31:0] w;
        logic [2:0]  kind; // 0 none, 1 3R, 2 sext, 3 zext, 4 store, 5 preld, 6 upper
        logic [7:0]  op;
        logic [2:0]  sel;
        w    = item.instr;
        kind = 3'd0;
        op   = '0;
        sel  = '0;
        case (w[31:15])
            `OP_ADD_W: {kind, op, sel} = {3'd1, ALU_ADD, SEL_ARITH};
            `OP_SUB_W: {kind, op, sel} = {3'd1, ALU_SUB, SEL_ARITH};
            `OP_SLT:   {kind, op, sel} = {3'd1, ALU_SLT, SEL_ARITH};
            `OP_SLTU:  {kind, op, sel} = {3'd1, ALU_SLTU, SEL_ARITH};
            `OP_MUL_W: {kind, op, sel} = {3'd1, ALU_MUL, SEL_ARITH};
            `OP_NOR:   {kind, op, sel} = {3'd1, ALU_NOR, SEL_LOGIC};
            `OP_AND:   {kind, op, sel} = {3'd1, ALU_AND, SEL_LOGIC};
            `OP_OR:    {kind, op, sel} = {3'd1, ALU_OR, SEL_LOGIC};
            `OP_XOR:   {kind, op, sel} = {3'd1, ALU_XOR, SEL_LOGIC};
            `OP_SLL_W: {kind, op, sel} = {3'd1, ALU_SLL, SEL_SHIFT};
            `OP_SRL_W: {kind, op, sel} = {3'd1, ALU_SRL, SEL_SHIFT};
            `OP_SRA_W: {kind, op, sel} = {3'd1, ALU_SRA, SEL_SHIFT};
            default: ;
        endcase
        case (w[31:22])
            `OP_SLTI:   {kind, op, sel} = {3'd2, ALU_SLT, SEL_ARITH};
            `OP_SLTUI:  {kind, op, sel} = {3'd2, ALU_SLTU, SEL_ARITH};
            `OP_ADDI_W: {kind, op, sel} = {3'd2, ALU_ADD, SEL_ARITH};
            `OP_ANDI:   {kind, op, sel} = {3'd3, ALU_AND, SEL_LOGIC};
            `OP_ORI:    {kind, op, sel} = {3'd3, ALU_OR, SEL_LOGIC};
            `OP_XORI:   {kind, op, sel} = {3'd3, ALU_XOR, SEL_LOGIC};
            `OP_LD_B:   {kind, op, sel} = {3'd2, ALU_LD_B, SEL_LOAD_STORE};
            `OP_LD_H:   {kind, op, sel} = {3'd2, ALU_LD_H, SEL_LOAD_STORE};
            `OP_LD_W:   {kind, op, sel} = {3'd2, ALU_LD_W, SEL_LOAD_STORE};
            `OP_LD_BU:  {kind, op, sel} = {3'd2, ALU_LD_BU, SEL_LOAD_STORE};
            `OP_LD_HU:  {kind, op, sel} = {3'd2, ALU_LD_HU, SEL_LOAD_STORE};
            `OP_ST_B:   {kind, op, sel} = {3'd4, ALU_ST_B, SEL_LOAD_STORE};
            `OP_ST_H:   {kind, op, sel} = {3'd4, ALU_ST_H, SEL_LOAD_STORE};
            `OP_ST_W:   {kind, op, sel} = {3'd4, ALU_ST_W, SEL_LOAD_STORE};
            `OP_PRELD:  {kind, op, sel} = {3'd5, ALU_NOP, SEL_NOP};
            default: ;
        endcase
        if (w[31:25] == `OP_LU12I_W || w[31:25] == `OP_PCADDU12I) begin
            {kind, op, sel} = {3'd6, ALU_ADD, SEL_ARITH};
        end
        o                  = '0;
        o.pc               = item.pc;
        o.illegal          = (kind == 3'd0);
        o.result.hit       = (kind != 3'd0);
        o.result.aluop     = aluop_t'(op);
        o.result.alusel    = alusel_t'(sel);
        o.result.rj        = (kind inside {3'd1, 3'd2, 3'd3, 3'd4, 3'd5}) ? w[9:5] : '0;
        o.result.rk        = (kind == 3'd1) ? w[14:10] : (kind == 3'd4) ? w[4:0] : '0;
        o.result.rd        = (kind inside {3'd1, 3'd2, 3'd3, 3'd6}) ? w[4:0] : '0;
        o.result.reg_write_valid = kind inside {3'd1, 3'd2, 3'd3, 3'd6};
        o.result.reg_read_valid  = (kind inside {3'd1, 3'd4}) ? 2'b11 :
                                   (kind inside {3'd2, 3'd3, 3'd5}) ? 2'b01 : 2'b00;
        if (kind == 3'd2 || kind == 3'd4) begin
            o.result.imm = {{20{w[21]}}, w[21:10]};
        end else if (kind == 3'd3) begin
            o.result.imm = {20'h0, w[21:10]};
        end else if (kind == 3'd6) begin
            o.result.imm    = {w[24:5], 12'h0};
            o.result.use_pc = (w[31:25] == `OP_PCADDU12I);
        end
        return o;
    endfunction

    // Two-entry model where flush beats stall
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_in_v  <= 1'b0;
            m_out_v <= 1'b0;
        end else if (flush_i) begin
            m_in_v  <= 1'b0;
            m_out_v <= 1'b0;
        end else if (!stall_i) begin
            m_out_v <= m_in_v;
            m_out   <= ref_decode(m_in);
            m_in_v  <= instr_valid_i;
            m_in    <= instr_i;
        end
    end

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        checks++;
        if (decoded_valid_o !== m_out_v) begin
            $display("MISMATCH decoded_valid_o expected 0x%0h actual 0x%0h",
                     m_out_v, decoded_valid_o);
            errors++;
        end
        if (m_out_v && decoded_valid_o) begin
            check_field("pc", m_out.pc, decoded_o.pc);
            check_field("hit", m_out.result.hit, decoded_o.result.hit);
            check_field("reg_read_valid", m_out.result.reg_read_valid,
                        decoded_o.result.reg_read_valid);
            check_field("rj", m_out.result.rj, decoded_o.result.rj);
            check_field("rk", m_out.result.rk, decoded_o.result.rk);
            check_field("imm", m_out.result.imm, decoded_o.result.imm);
            check_field("use_pc", m_out.result.use_pc, decoded_o.result.use_pc);
            check_field("reg_write_valid", m_out.result.reg_write_valid,
                        decoded_o.result.reg_write_valid);
            check_field("rd", m_out.result.rd, decoded_o.result.rd);
            check_field("aluop", m_out.result.aluop, decoded_o.result.aluop);
            check_field("alusel", m_out.result.alusel, decoded_o.result.alusel);
            check_field("illegal", m_out.illegal, decoded_o.illegal);
        end
    endtask

    // Check what the last edge produced and drive the next cycle
    task automatic step(input logic v, input instr_buffer_info_t item, input logic st,
                        input logic fl);
        @(negedge clk_i);
        compare_outputs();
        instr_valid_i = v;
        instr_i       = item;
        stall_i       = st;
        flush_i       = fl;
    endtask

    task automatic send(input logic [31:0] w);
        step(1'b1, next_item(w), 1'b0, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic report(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("%-12s done, no errors", name);
        end else begin
            $display("%-12s done, %0d errors", name, errors - e0);
        end
    endtask

    task automatic reset_seq();
        int e0;
        e0 = errors;
        arst_n_i = 1'b0;
        // Words offered during reset must not get through
        repeat (8) begin
            step(1'b1, next_item(rand_word(`OP_ADD_W, 17)), 1'b0, 1'b0);
        end
        arst_n_i      = 1'b1;
        instr_valid_i = 1'b0;
        idle(2);
        report("reset", e0);
    endtask

    task automatic imm_alu_ops();
        logic [9:0] ops [6];
        int         e0;
        e0  = errors;
        ops = '{`OP_SLTI, `OP_SLTUI, `OP_ADDI_W, `OP_ANDI, `OP_ORI, `OP_XORI};
        foreach (ops[i]) send(rand_word(ops[i], 10) | 32'h0020_0000); // imm[11] set
        idle(2);
        report("imm_alu", e0);
    endtask

    task automatic mem_ops();
        logic [9:0] ops [9];
        int         e0;
        e0  = errors;
        ops = '{`OP_LD_B, `OP_LD_H, `OP_LD_W, `OP_LD_BU, `OP_LD_HU,
                `OP_ST_B, `OP_ST_H, `OP_ST_W, `OP_PRELD};
        foreach (ops[i]) send(rand_word(ops[i], 10));
        idle(2);
        report("mem", e0);
    endtask

    task automatic reg_upper_ops();
        logic [16:0] ops [12];
        int          e0;
        e0  = errors;
        ops = '{`OP_ADD_W, `OP_SUB_W, `OP_SLT, `OP_SLTU, `OP_NOR, `OP_AND,
                `OP_OR, `OP_XOR, `OP_SLL_W, `OP_SRL_W, `OP_SRA_W, `OP_MUL_W};
        foreach (ops[i]) send(rand_word(ops[i], 17));
        send(rand_word(`OP_LU12I_W, 7));
        send(rand_word(`OP_PCADDU12I, 7));
        idle(2);
        report("3r_1ri20", e0);
    endtask

    task automatic illegal_ops();
        int e0;
        e0 = errors;
        send(32'h0000_0000);
        send(32'hffff_ffff);
        send(rand_word(17'h00021, 17));
        send(rand_word(10'h0a3, 10));
        send(rand_word(10'h0aa, 10));
        send(rand_word(7'h0b, 7));
        idle(2);
        report("illegal", e0);
    endtask

    task automatic stall_flush_stream();
        instr_buffer_info_t held;
        int                 e0;
        e0 = errors;
        send(rand_word(`OP_ADD_W, 17));
        send(rand_word(`OP_ORI, 10));
        held = next_item(rand_word(`OP_LD_W, 10));
        repeat (3) step(1'b1, held, 1'b1, 1'b0); // Source keeps its word
        step(1'b1, held, 1'b0, 1'b0);
        send(rand_word(`OP_SUB_W, 17));
        send(rand_word(`OP_LU12I_W, 7));
        // Drops the word in the input register and the one offered
        step(1'b1, next_item(rand_word(`OP_XOR, 17)), 1'b0, 1'b1);
        send(rand_word(`OP_ST_W, 10));
        idle(1);
        send(rand_word(`OP_SLTI, 10));
        step(1'b1, next_item(rand_word(`OP_AND, 17)), 1'b1, 1'b1);
        send(rand_word(`OP_PCADDU12I, 7));
        idle(3);
        report("stall_flush", e0);
    endtask

    initial begin
        #((TOTAL_CYC + MARGIN_CYC) * 10);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        reset_seq();
        imm_alu_ops();
        mem_ops();
        reg_upper_ops();
        illegal_ops();
        stall_flush_stream();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== decode_stage.f ====
+incdir+design
design/la_isa_pkg.sv
design/decode_pkg.sv
design/decoder_3r.sv
design/decoder_2ri12.sv
design/decoder_1ri20.sv
design/decode_core.sv
design/pipe_reg.sv
design/decode_stage.sv
tests/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - design
    files:
      - design/la_isa_pkg.sv
      - design/decode_pkg.sv
      - design/decoder_3r.sv
      - design/decoder_2ri12.sv
      - design/decoder_1ri20.sv
      - design/decode_core.sv
      - design/pipe_reg.sv
      - design/decode_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_decode_stage.sv
